// ==== vlog.f ====
+incdir+.
arith_pkg.sv
mac_pkg.sv
loa_adder.sv
nr_mul.sv
approx_mul8.sv
mac_accum.sv
mac_ctrl.sv
approx_mac_top.sv
tb_approx_mac.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_approx_mac
RTL_TOP    ?= approx_mac_top
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/1ps
PASS_TEXT  ?= ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== tb_mac_model.svh ====
`ifndef TB_MAC_MODEL_SVH
`define TB_MAC_MODEL_SVH

// lower-part-OR sum of two w-bit values into w+1 bits.
function automatic int unsigned loa_sum(input int unsigned x, input int unsigned y,
                                        input int w, input int k);
    int unsigned wm;
    int unsigned lm;
    wm = (32'd1 << w) - 1;
    lm = (32'd1 << k) - 1;
    x = x & wm;
    y = y & wm;
    return (((x >> k) + (y >> k)) << k) | ((x | y) & lm);
endfunction

// one split step joining the four sub-products.
// lw is the low part width and wm and wh are the adder widths.
function automatic int unsigned split_join(input int unsigned hh, input int unsigned hl,
                                           input int unsigned lh, input int unsigned ll,
                                           input int lw, input int wm, input int wh,
                                           input int kh);
    int unsigned mid;
    int unsigned hi;
    mid = loa_sum(hl, lh, wm, 0);
    hi  = loa_sum((hh << (2 * lw - lw)) | (ll >> lw), mid, wh, kh);
    return ((hi & ((32'd1 << wh) - 1)) << lw) | (ll & ((32'd1 << lw) - 1));
endfunction

// the carry of the 3-bit high adder is the top product bit.
function automatic int unsigned rr3_hi_product(input int unsigned a, input int unsigned b);
    return split_join((a >> 2) * (b >> 2), (a >> 2) * (b & 3), (a & 3) * (b >> 2),
                      (a & 3) * (b & 3), 2, 2, 4, 0);
endfunction

// the 1x1 product has no upper part so the high term is padded by one bit.
function automatic int unsigned rr3_lo_product(input int unsigned a, input int unsigned b);
    return split_join((a >> 1) * (b >> 1), (a >> 1) * (b & 1), (a & 1) * (b >> 1),
                      (a & 1) * (b & 1), 1, 2, 5, 2);
endfunction

function automatic int unsigned rr6_product(input int unsigned a, input int unsigned b);
    return split_join(rr3_hi_product(a >> 3, b >> 3), (a >> 3) * (b & 7),
                      (a & 7) * (b >> 3), rr3_lo_product(a & 7, b & 7), 3, 6, 9, 2);
endfunction

function automatic int unsigned mul8_product(input int unsigned a, input int unsigned b);
    return split_join(rr6_product(a >> 2, b >> 2), (a >> 2) * (b & 3), (a & 3) * (b >> 2),
                      (a & 3) * (b & 3), 2, 8, 14, 5) & 32'hFFFF;
endfunction

// sat stays set until a clear.
function automatic int unsigned acc_step(input int unsigned acc, input int unsigned prod,
                                         input bit clear, input bit sat_en, inout bit sat);
    longint unsigned sum;
    if (clear) begin
        sat = 1'b0;
        return prod;
    end
    sum = longint'(acc) + longint'(prod);
    if (sum > 64'hFF_FFFF) begin
        sat = 1'b1;
        return sat_en ? 32'hFF_FFFF : int'(sum & 64'hFF_FFFF);
    end
    return int'(sum);
endfunction

`endif

// ==== tb_approx_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_approx_mac;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 5;
    localparam int RESET_CYCLES = 3;
    localparam int ACK_EDGES    = 3;
    localparam int MAX_WAIT     = 20;
    localparam bit SAT_EN       = 1'b1;
    localparam int CORNER_JOBS  = 24;
    localparam int RAND_JOBS    = 500;
    localparam int SAT_JOBS     = 270;
    // first job, corners, random run, back-pressure job, saturation run and its clear.
    localparam int TOTAL_JOBS   = 1 + CORNER_JOBS + RAND_JOBS + 1 + SAT_JOBS + 1;
    localparam int WATCHDOG_NS  = CLK_PERIOD * 10 * TOTAL_JOBS;

    logic              clk;
    logic              rst_n;
    logic              req;
    mac_pkg::mac_req_t req_data;
    logic              ack;
    mac_pkg::mac_rsp_t rsp_data;

    arith_pkg::acc_t   exp_acc;
    bit                exp_sat;
    logic [31:0]       rng_state;

    `include "tb_mac_model.svh"

    approx_mac_top #(.ACC_SAT_EN(SAT_EN)) i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp_data (rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all jobs were done");
        $display("** FAIL **");
        $fatal(1, "run stopped by the watchdog");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic arith_pkg::product_t approx_product(input arith_pkg::operand_t a,
                                                            input arith_pkg::operand_t b);
        return arith_pkg::product_t'(mul8_product(32'(a), 32'(b)));
    endfunction

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic product_check(input arith_pkg::product_t got,
                                 input arith_pkg::product_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0d ns: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic acc_check(input arith_pkg::acc_t got, input arith_pkg::acc_t exp,
                             input string what);
        if (got !== exp) begin
            $display("error at %0d ns: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic flag_check(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error at %0d ns: %s got %b expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // one full four-phase job.
    // hold keeps req high for extra cycles.
    task automatic run_job(input arith_pkg::operand_t a, input arith_pkg::operand_t b,
                           input logic clear, input int hold);
        mac_pkg::mac_req_t   job;
        arith_pkg::product_t exp_prod;
        int                  edges;
        job.a     = a;
        job.b     = b;
        job.clear = clear;
        exp_prod  = approx_product(a, b);
        exp_acc   = arith_pkg::acc_t'(acc_step(32'(exp_acc), 32'(exp_prod), clear, SAT_EN,
                                               exp_sat));
        req_data  = job;
        req       = 1'b1;
        edges     = 0;
        while (!ack && edges < MAX_WAIT) begin
            @(posedge clk);
            #DRIVE_DLY;
            edges++;
        end
        if (!ack) begin
            $display("ack never rose for operands %0d and %0d", a, b);
            abort_run();
        end
        if (edges != ACK_EDGES) begin
            $display("ack rose %0d edges after req instead of %0d", edges, ACK_EDGES);
            abort_run();
        end
        product_check(rsp_data.product, exp_prod, "product");
        acc_check(rsp_data.acc, exp_acc, "acc");
        flag_check(rsp_data.sat, exp_sat, "sat");
        repeat (hold) begin
            @(posedge clk);
            #DRIVE_DLY;
            flag_check(ack, 1'b1, "ack while req held");
            product_check(rsp_data.product, exp_prod, "product while req held");
            acc_check(rsp_data.acc, exp_acc, "acc while req held");
            flag_check(rsp_data.sat, exp_sat, "sat while req held");
        end
        req = 1'b0;
        @(posedge clk);
        #DRIVE_DLY;
        if (ack) begin
            $display("ack still high one edge after req was dropped");
            abort_run();
        end
    endtask

    task automatic first_job_after_reset();
        flag_check(ack, 1'b0, "ack after reset");
        acc_check(rsp_data.acc, '0, "acc after reset");
        flag_check(rsp_data.sat, 1'b0, "sat after reset");
        run_job(8'hB7, 8'h6D, 1'b1, 0);
    endtask

    task automatic corner_operands();
        run_job(8'd0, 8'h5A, 1'b1, 0);
        run_job(8'hC3, 8'd0, 1'b1, 0);
        run_job(8'd0, 8'd0, 1'b1, 0);
        run_job(8'd1, 8'd1, 1'b1, 0);
        run_job(8'd3, 8'd3, 1'b1, 0);
        run_job(8'd255, 8'd255, 1'b1, 0);
        run_job(8'd224, 8'd224, 1'b1, 0);
        run_job(8'd255, 8'd1, 1'b1, 0);
        for (int i = 0; i < 8; i++) begin
            run_job(8'd1 << i, 8'd1 << (7 - i), 1'b1, 0);
            run_job(8'd1 << i, 8'd1 << i, 1'b1, 0);
        end
    endtask

    task automatic random_accumulation();
        for (int i = 0; i < RAND_JOBS; i++) begin
            rng_state = xorshift32(rng_state);
            run_job(rng_state[7:0], rng_state[15:8], i == 0, 0);
        end
    endtask

    task automatic back_pressure_hold();
        run_job(8'h5C, 8'hE3, 1'b0, 10);
    endtask

    task automatic saturate_and_clear();
        run_job(8'd255, 8'd255, 1'b1, 0);
        for (int i = 1; i < SAT_JOBS; i++) begin
            run_job(8'd255, 8'd255, 1'b0, 0);
        end
        acc_check(rsp_data.acc, '1, "acc after overflow");
        flag_check(rsp_data.sat, 1'b1, "sat after overflow");
        run_job(8'd255, 8'd255, 1'b1, 0);
        flag_check(rsp_data.sat, 1'b0, "sat after clear");
    endtask

    initial begin
        exp_acc     = '0;
        exp_sat     = 1'b0;
        rng_state   = 32'd78;
        rst_n       = 1'b0;
        req         = 1'b0;
        req_data    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        first_job_after_reset();
        corner_operands();
        random_accumulation();
        back_pressure_hold();
        saturate_and_clear();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== approx_mac_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module approx_mac_top #(
    parameter bit ACC_SAT_EN = 1'b1
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req,
    input  mac_pkg::mac_req_t req_data,
    output logic              ack,
    output mac_pkg::mac_rsp_t rsp_data
);

    arith_pkg::operand_t a;
    arith_pkg::operand_t b;
    arith_pkg::product_t product;
    arith_pkg::product_t prod;
    arith_pkg::acc_t     acc;
    logic                clear;
    logic                acc_load;
    logic                sat;

    mac_ctrl i_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .req_data (req_data),
        .product  (product),
        .acc      (acc),
        .sat      (sat),
        .ack      (ack),
        .a        (a),
        .b        (b),
        .clear    (clear),
        .acc_load (acc_load),
        .prod     (prod),
        .rsp_data (rsp_data)
    );

    approx_mul8 i_mul (.a(a), .b(b), .p(product));

    mac_accum #(.ACC_SAT_EN(ACC_SAT_EN)) i_accum (
        .clk      (clk),
        .rst_n    (rst_n),
        .acc_load (acc_load),
        .clear    (clear),
        .product  (prod),
        .acc      (acc),
        .sat      (sat)
    );

endmodule

`default_nettype wire

// ==== mac_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req,
    input  mac_pkg::mac_req_t   req_data,
    input  arith_pkg::product_t product,
    input  arith_pkg::acc_t     acc,
    input  logic                sat,
    output logic                ack,
    output arith_pkg::operand_t a,
    output arith_pkg::operand_t b,
    output logic                clear,
    output logic                acc_load,
    output arith_pkg::product_t prod,
    output mac_pkg::mac_rsp_t   rsp_data
);

    mac_pkg::ctrl_state_t state;
    mac_pkg::ctrl_state_t state_next;
    mac_pkg::mac_req_t    op_q;
    logic                 op_load;
    logic                 prod_load;

    // new job only from idle with the previous ack gone.
    assign op_load   = (state == mac_pkg::IDLE) && req && !ack;
    assign prod_load = (state == mac_pkg::MUL);
    assign acc_load  = (state == mac_pkg::ACC);

    always_comb begin
        state_next = state;
        case (state)
            mac_pkg::IDLE: if (op_load) state_next = mac_pkg::MUL;
            mac_pkg::MUL:  state_next = mac_pkg::ACC;
            mac_pkg::ACC:  state_next = mac_pkg::DONE;
            mac_pkg::DONE: if (!req) state_next = mac_pkg::IDLE;
            default:       state_next = mac_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= mac_pkg::IDLE;
            ack   <= 1'b0;
        end else begin
            state <= state_next;
            if (acc_load) begin
                ack <= 1'b1;
            end else if (state == mac_pkg::DONE && !req) begin
                ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_load) begin
            op_q <= req_data;
        end
        if (prod_load) begin
            prod <= product;
        end
    end

    assign a     = op_q.a;
    assign b     = op_q.b;
    assign clear = op_q.clear;

    // held steady through back-pressure, nothing loads in DONE.
    assign rsp_data = '{product: prod, acc: acc, sat: sat};

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req));

    a_req_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (req && !ack) ##1 (req && !ack) |-> $stable(req_data));

    a_acc_load_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        acc_load |=> !acc_load);

endmodule

`default_nettype wire

// ==== mac_accum.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_accum #(
    parameter bit ACC_SAT_EN = 1'b1
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                acc_load,
    input  logic                clear,
    input  arith_pkg::product_t product,
    output arith_pkg::acc_t     acc,
    output logic                sat
);

    localparam int PROD_W = $bits(arith_pkg::product_t);

    logic [arith_pkg::ACC_W-1:0] prod_ext;
    logic [arith_pkg::ACC_W:0]   sum;
    logic                        ovf;

    assign prod_ext = {{(arith_pkg::ACC_W - PROD_W){1'b0}}, product};
    assign sum      = {1'b0, acc} + {1'b0, prod_ext};
    assign ovf      = sum[arith_pkg::ACC_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc <= '0;
            sat <= 1'b0;
        end else if (acc_load) begin
            if (clear) begin
                acc <= prod_ext;
                sat <= 1'b0;
            end else begin
                if (ovf && ACC_SAT_EN) begin
                    acc <= '1;
                end else begin
                    acc <= sum[arith_pkg::ACC_W-1:0];
                end
                // sticky until the next clear.
                sat <= sat | ovf;
            end
        end
    end

    a_sat_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
        (ACC_SAT_EN && acc_load && !clear) |=> (acc >= $past(acc)));

endmodule

`default_nettype wire

// ==== approx_mul8.sv ====
`timescale 1ns/1ps
`default_nettype none

// 8x8 recursive approximate multiplier, 6/2 split.
module approx_mul8 (
    input  arith_pkg::operand_t a,
    input  arith_pkg::operand_t b,
    output arith_pkg::product_t p
);

    logic [5:0]  a_h;
    logic [5:0]  b_h;
    logic [1:0]  a_l;
    logic [1:0]  b_l;
    logic [11:0] p_hh;
    logic [7:0]  p_hl;
    logic [7:0]  p_lh;
    logic [3:0]  p_ll;
    logic [8:0]  sum_mid;
    logic [13:0] op_hi;
    logic [14:0] sum_hi;

    assign a_h = a[7:2];
    assign b_h = b[7:2];
    assign a_l = a[1:0];
    assign b_l = b[1:0];

    rr_6x6 i_m_hh (.a(a_h), .b(b_h), .p(p_hh));

    nr_mul #(.WA(6), .WB(2)) i_m_hl (.x(a_h), .y(b_l), .p(p_hl));
    nr_mul #(.WA(2), .WB(6)) i_m_lh (.x(a_l), .y(b_h), .p(p_lh));
    nr_mul #(.WA(2), .WB(2)) i_m_ll (.x(a_l), .y(b_l), .p(p_ll));

    loa_adder #(.W(8), .K(0)) i_add_mid (.x(p_hl), .y(p_lh), .s(sum_mid));

    assign op_hi = {p_hh, p_ll[3:2]};

    loa_adder #(.W(14), .K(5)) i_add_hi (
        .x(op_hi),
        .y({5'b0, sum_mid}),
        .s(sum_hi)
    );

    // top carry is always zero, the approximate sum never exceeds the exact one.
    assign p = {sum_hi[13:0], p_ll[1:0]};

endmodule

// 6x6 stage, 3/3 split.
module rr_6x6 (
    input  logic [5:0]  a,
    input  logic [5:0]  b,
    output logic [11:0] p
);

    logic [5:0] p_hh;
    logic [5:0] p_hl;
    logic [5:0] p_lh;
    logic [5:0] p_ll;
    logic [6:0] sum_mid;
    logic [8:0] op_hi;
    logic [9:0] sum_hi;

    rr_3x3_hi i_m_hh (.a(a[5:3]), .b(b[5:3]), .p(p_hh));

    nr_mul #(.WA(3), .WB(3)) i_m_hl (.x(a[5:3]), .y(b[2:0]), .p(p_hl));
    nr_mul #(.WA(3), .WB(3)) i_m_lh (.x(a[2:0]), .y(b[5:3]), .p(p_lh));

    rr_3x3_lo i_m_ll (.a(a[2:0]), .b(b[2:0]), .p(p_ll));

    loa_adder #(.W(6), .K(0)) i_add_mid (.x(p_hl), .y(p_lh), .s(sum_mid));

    assign op_hi = {p_hh, p_ll[5:3]};

    loa_adder #(.W(9), .K(2)) i_add_hi (
        .x(op_hi),
        .y({2'b00, sum_mid}),
        .s(sum_hi)
    );

    assign p = {sum_hi[8:0], p_ll[2:0]};

endmodule

// 3x3 stage for the high operand halves, 1/2 split.
module rr_3x3_hi (
    input  logic [2:0] a,
    input  logic [2:0] b,
    output logic [5:0] p
);

    logic [1:0] p_hh;
    logic [2:0] p_hl;
    logic [2:0] p_lh;
    logic [3:0] p_ll;
    logic [2:0] sum_mid;
    logic [2:0] op_hi;
    logic [3:0] sum_hi;

    nr_mul #(.WA(1), .WB(1)) i_m_hh (.x(a[2]),   .y(b[2]),   .p(p_hh));
    nr_mul #(.WA(1), .WB(2)) i_m_hl (.x(a[2]),   .y(b[1:0]), .p(p_hl));
    nr_mul #(.WA(2), .WB(1)) i_m_lh (.x(a[1:0]), .y(b[2]),   .p(p_lh));
    nr_mul #(.WA(2), .WB(2)) i_m_ll (.x(a[1:0]), .y(b[1:0]), .p(p_ll));

    // 1x2 products never exceed 3.
    loa_adder #(.W(2), .K(0)) i_add_mid (
        .x(p_hl[1:0]),
        .y(p_lh[1:0]),
        .s(sum_mid)
    );

    assign op_hi = {p_hh[0], p_ll[3:2]};

    loa_adder #(.W(3), .K(0)) i_add_hi (.x(op_hi), .y(sum_mid), .s(sum_hi));

    assign p = {sum_hi, p_ll[1:0]};

endmodule

// 3x3 stage for the low operand halves, 2/1 split.
module rr_3x3_lo (
    input  logic [2:0] a,
    input  logic [2:0] b,
    output logic [5:0] p
);

    logic [3:0] p_hh;
    logic [2:0] p_hl;
    logic [2:0] p_lh;
    logic [1:0] p_ll;
    logic [2:0] sum_mid;
    logic [4:0] op_hi;
    logic [5:0] sum_hi;

    nr_mul #(.WA(2), .WB(2)) i_m_hh (.x(a[2:1]), .y(b[2:1]), .p(p_hh));
    nr_mul #(.WA(2), .WB(1)) i_m_hl (.x(a[2:1]), .y(b[0]),   .p(p_hl));
    nr_mul #(.WA(1), .WB(2)) i_m_lh (.x(a[0]),   .y(b[2:1]), .p(p_lh));
    nr_mul #(.WA(1), .WB(1)) i_m_ll (.x(a[0]),   .y(b[0]),   .p(p_ll));

    loa_adder #(.W(2), .K(0)) i_add_mid (
        .x(p_hl[1:0]),
        .y(p_lh[1:0]),
        .s(sum_mid)
    );

    // no upper bits from the 1x1 product, zero pad.
    assign op_hi = {p_hh, 1'b0};

    loa_adder #(.W(5), .K(2)) i_add_hi (
        .x(op_hi),
        .y({2'b00, sum_mid}),
        .s(sum_hi)
    );

    assign p = {sum_hi[4:0], p_ll[0]};

endmodule

`default_nettype wire

// ==== nr_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

// exact unsigned multiplier for the small sub-products.
module nr_mul #(
    parameter int WA = 2,
    parameter int WB = 2
) (
    input  logic [WA-1:0]    x,
    input  logic [WB-1:0]    y,
    output logic [WA+WB-1:0] p
);

    logic [WA+WB-1:0] x_ext;
    logic [WA+WB-1:0] y_ext;

    assign x_ext = {{WB{1'b0}}, x};
    assign y_ext = {{WA{1'b0}}, y};

    assign p = x_ext * y_ext;

endmodule

`default_nettype wire

// ==== loa_adder.sv ====
`timescale 1ns/1ps
`default_nettype none

// lower-part-OR adder.
// the lowest K bits are a plain OR and produce no carry, the rest is an exact sum.
module loa_adder #(
    parameter int W = 8,
    parameter int K = 0
) (
    input  logic [W-1:0] x,
    input  logic [W-1:0] y,
    output logic [W:0]   s
);

    if (K > 0) begin : g_lower_or
        assign s[K-1:0] = x[K-1:0] | y[K-1:0];
    end

    // upper part, carry-in is zero by construction.
    assign s[W:K] = {1'b0, x[W-1:K]} + {1'b0, y[W-1:K]};

endmodule

`default_nettype wire

// ==== mac_pkg.sv ====
`default_nettype none

package mac_pkg;

    // one job as handed over by the requester.
    typedef struct packed {
        arith_pkg::operand_t a;
        arith_pkg::operand_t b;
        logic                clear;
    } mac_req_t;

    // result returned while ack is high.
    typedef struct packed {
        arith_pkg::product_t product;
        arith_pkg::acc_t     acc;
        logic                sat;
    } mac_rsp_t;

    // job sequencing in mac_ctrl.
    typedef enum logic [1:0] {
        IDLE,
        MUL,
        ACC,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== arith_pkg.sv ====
`default_nettype none

package arith_pkg;

    // accumulator width, wide enough for 256 full-scale products.
    localparam int ACC_W = 24;

    // multiplier operand.
    typedef logic [7:0] operand_t;

    // approximate product of two operands.
    typedef logic [15:0] product_t;

    // running sum.
    typedef logic [ACC_W-1:0] acc_t;

endpackage

`default_nettype wire
